//--- hw/cache_pkg.sv
`default_nettype none

package cache_pkg;

  // cache and dram geometry.
  localparam int line_bytes = 16;
  localparam int word_bytes = 4;
  localparam int dram_lines = 1024;
  localparam int cache_sets = 16;

  localparam int dram_bytes     = dram_lines * line_bytes;
  localparam int words_per_line = line_bytes / word_bytes;
  localparam int byte_sel_bits  = $clog2(word_bytes);      // ignored low bits.
  localparam int word_sel_bits  = $clog2(words_per_line);
  localparam int offset_bits    = $clog2(line_bytes);
  localparam int index_bits     = $clog2(cache_sets);
  localparam int line_addr_bits = $clog2(dram_lines);
  localparam int tag_bits       = line_addr_bits - index_bits;
  localparam int byte_addr_bits = line_addr_bits + offset_bits;
  localparam int word_bits      = 8 * word_bytes;
  localparam int line_bits      = 8 * line_bytes;

  typedef logic [byte_addr_bits-1:0] byte_addr_t;
  typedef logic [line_addr_bits-1:0] line_addr_t; // {tag, index}.
  typedef logic [tag_bits-1:0]       tag_t;
  typedef logic [index_bits-1:0]     index_t;
  typedef logic [word_sel_bits-1:0]  word_sel_t;
  typedef logic [word_bits-1:0]      word_t;
  typedef logic [line_bits-1:0]      line_t;  // little endian, word k at bit 32k.

  typedef enum logic [2:0] {
    idle,
    lookup,
    writeback,
    fill,
    respond
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/dram.sv
`default_nettype none

module dram (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wren,
  input  logic                  rden,
  input  cache_pkg::line_addr_t addr,
  input  cache_pkg::line_t      data_in,
  output cache_pkg::line_t      data_out,
  output logic                  mem_ready
);

  logic [7:0]            mem [0:cache_pkg::dram_bytes-1];
  cache_pkg::byte_addr_t base_addr;
  logic [1:0]            cnt;
  logic                  strobe;
  logic                  fire;

  // every byte starts as the low bits of its own address.
  initial begin
    for (int i = 0; i < cache_pkg::dram_bytes; i++) begin
      mem[i] = 8'(i);
    end
  end

  assign base_addr = {addr, {cache_pkg::offset_bits{1'b0}}};
  assign strobe    = wren | rden;
  assign fire      = strobe && (cnt == 2'd2); // third strobe cycle, ready on the fourth.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt       <= 2'd0;
      mem_ready <= 1'b0;
    end else if (strobe) begin
      cnt       <= cnt + 2'd1;
      mem_ready <= fire;
    end else begin
      cnt       <= 2'd0;                      // idle bus restarts the latency.
      mem_ready <= 1'b0;
    end
  end

  // whole line moves on the edge into the mem_ready cycle.
  always_ff @(posedge clk) begin
    if (fire) begin
      for (int b = 0; b < cache_pkg::line_bytes; b++) begin
        if (wren && !rden) begin
          mem[base_addr + b] <= data_in[8*b +: 8];
        end else if (rden && !wren) begin
          data_out[8*b +: 8] <= mem[base_addr + b];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/cache_arrays.sv
`default_nettype none

module cache_arrays (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               rd_en,
  input  cache_pkg::index_t  rd_index,
  output cache_pkg::tag_t    tag,
  output logic               valid,
  output logic               dirty,
  output cache_pkg::line_t   line,
  input  logic               wr_en,
  input  cache_pkg::index_t  wr_index,
  input  cache_pkg::tag_t    wr_tag,
  input  cache_pkg::line_t   wr_line,
  input  logic               wr_dirty
);

  cache_pkg::tag_t           tag_mem   [cache_pkg::cache_sets];
  cache_pkg::line_t          line_mem  [cache_pkg::cache_sets];
  logic                      dirty_mem [cache_pkg::cache_sets];
  logic [cache_pkg::cache_sets-1:0] valid_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;                          // all sets empty.
    end else if (wr_en) begin
      valid_q[wr_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      tag_mem[wr_index]   <= wr_tag;
      line_mem[wr_index]  <= wr_line;
      dirty_mem[wr_index] <= wr_dirty;
    end
  end

  // registered read, sees the contents from before a same-cycle write.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid <= 1'b0;
    end else if (rd_en) begin
      valid <= valid_q[rd_index];
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      tag   <= tag_mem[rd_index];
      line  <= line_mem[rd_index];
      dirty <= dirty_mem[rd_index];
    end
  end

endmodule

`default_nettype wire

//--- hw/cache_ctrl.sv
`default_nettype none

module cache_ctrl (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req,
  input  logic                  we,
  input  cache_pkg::byte_addr_t addr,
  input  cache_pkg::word_t      wdata,
  output cache_pkg::word_t      rdata,
  output logic                  busy,
  output logic                  done,
  output logic                  hit,
  output logic                  arr_rd_en,
  output cache_pkg::index_t     arr_rd_index,
  input  cache_pkg::tag_t       arr_tag,
  input  logic                  arr_valid,
  input  logic                  arr_dirty,
  input  cache_pkg::line_t      arr_line,
  output logic                  arr_wr_en,
  output cache_pkg::index_t     arr_wr_index,
  output cache_pkg::tag_t       arr_wr_tag,
  output cache_pkg::line_t      arr_wr_line,
  output logic                  arr_wr_dirty,
  output logic                  wren,
  output logic                  rden,
  output cache_pkg::line_addr_t line_addr,
  output cache_pkg::line_t      wr_line,
  input  cache_pkg::line_t      rd_line,
  input  logic                  mem_ready
);

  localparam int tag_lsb = cache_pkg::offset_bits + cache_pkg::index_bits;

  cache_pkg::ctrl_state_t state;

  cache_pkg::byte_addr_t  req_addr;
  logic                   req_we;
  cache_pkg::word_t       req_wdata;
  cache_pkg::tag_t        req_tag;
  cache_pkg::index_t      req_index;
  cache_pkg::word_sel_t   req_word;

  cache_pkg::line_t       line_q;
  cache_pkg::line_t       merged;
  cache_pkg::line_addr_t  line_addr_q;
  logic                   hit_q;
  logic                   dirty_q;
  logic                   strobe_q;
  logic                   drop_q;
  logic                   lookup_hit;
  logic                   victim_dirty;

  assign req_tag   = req_addr[tag_lsb +: cache_pkg::tag_bits];
  assign req_index = req_addr[cache_pkg::offset_bits +: cache_pkg::index_bits];
  assign req_word  = req_addr[cache_pkg::byte_sel_bits +: cache_pkg::word_sel_bits];

  assign lookup_hit   = arr_valid && (arr_tag == req_tag);
  assign victim_dirty = arr_valid && arr_dirty;

  // set read starts in the req cycle so lookup has the entry.
  assign arr_rd_en    = (state == cache_pkg::idle) && req;
  assign arr_rd_index = addr[cache_pkg::offset_bits +: cache_pkg::index_bits];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= cache_pkg::idle;
      hit_q    <= 1'b0;
      strobe_q <= 1'b0;
      drop_q   <= 1'b0;
    end else begin
      case (state)
        cache_pkg::idle: begin
          if (req) begin
            state <= cache_pkg::lookup;
          end
        end
        cache_pkg::lookup: begin
          hit_q <= lookup_hit;
          if (lookup_hit) begin
            state <= cache_pkg::respond;
          end else if (victim_dirty) begin
            state <= cache_pkg::writeback;
          end else begin
            state <= cache_pkg::fill;
          end
        end
        cache_pkg::writeback, cache_pkg::fill: begin
          if (drop_q) begin
            drop_q <= 1'b0;
            if (state == cache_pkg::writeback) begin
              state    <= cache_pkg::fill;
              strobe_q <= 1'b1;               // fill starts straight after the drop.
            end else begin
              state <= cache_pkg::respond;
            end
          end else if (strobe_q) begin
            if (mem_ready) begin
              strobe_q <= 1'b0;
              drop_q   <= 1'b1;
            end
          end else begin
            strobe_q <= 1'b1;                 // address settles one cycle first.
          end
        end
        cache_pkg::respond: begin
          state <= cache_pkg::idle;
        end
        default: begin
          state <= cache_pkg::idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == cache_pkg::idle) && req) begin
      req_addr  <= addr;
      req_we    <= we;
      req_wdata <= wdata;
    end
    if (state == cache_pkg::lookup) begin
      line_q      <= arr_line;
      dirty_q     <= arr_dirty;
      line_addr_q <= victim_dirty ? {arr_tag, req_index} : {req_tag, req_index};
    end
    if ((state == cache_pkg::writeback) && drop_q) begin
      line_addr_q <= {req_tag, req_index};    // now point at the missed line.
    end
    if ((state == cache_pkg::fill) && strobe_q && mem_ready) begin
      line_q <= rd_line;
    end
  end

  always_comb begin
    merged = line_q;
    if (req_we) begin
      merged[req_word * cache_pkg::word_bits +: cache_pkg::word_bits] = req_wdata;
    end
  end

  assign rdata = line_q[req_word * cache_pkg::word_bits +: cache_pkg::word_bits];
  assign busy  = (state != cache_pkg::idle);
  assign done  = (state == cache_pkg::respond);
  assign hit   = hit_q;

  // entry is rewritten on every access, dirty sticks on a hit.
  assign arr_wr_en    = (state == cache_pkg::respond);
  assign arr_wr_index = req_index;
  assign arr_wr_tag   = req_tag;
  assign arr_wr_line  = merged;
  assign arr_wr_dirty = req_we | (hit_q & dirty_q);

  assign wren      = (state == cache_pkg::writeback) && strobe_q;
  assign rden      = (state == cache_pkg::fill) && strobe_q;
  assign line_addr = line_addr_q;
  assign wr_line   = line_q;                  // victim line during write-back.

endmodule

`default_nettype wire

//--- hw/cache_top.sv
`default_nettype none

module cache_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req,
  input  logic                  we,
  input  cache_pkg::byte_addr_t addr,
  input  cache_pkg::word_t      wdata,
  output cache_pkg::word_t      rdata,
  output logic                  busy,
  output logic                  done,
  output logic                  hit
);

  logic                  arr_rd_en;
  cache_pkg::index_t     arr_rd_index;
  cache_pkg::tag_t       arr_tag;
  logic                  arr_valid;
  logic                  arr_dirty;
  cache_pkg::line_t      arr_line;
  logic                  arr_wr_en;
  cache_pkg::index_t     arr_wr_index;
  cache_pkg::tag_t       arr_wr_tag;
  cache_pkg::line_t      arr_wr_line;
  logic                  arr_wr_dirty;

  logic                  wren;
  logic                  rden;
  cache_pkg::line_addr_t line_addr;
  cache_pkg::line_t      wr_line;
  cache_pkg::line_t      rd_line;
  logic                  mem_ready;

  cache_ctrl ctrl_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (req),
    .we           (we),
    .addr         (addr),
    .wdata        (wdata),
    .rdata        (rdata),
    .busy         (busy),
    .done         (done),
    .hit          (hit),
    .arr_rd_en    (arr_rd_en),
    .arr_rd_index (arr_rd_index),
    .arr_tag      (arr_tag),
    .arr_valid    (arr_valid),
    .arr_dirty    (arr_dirty),
    .arr_line     (arr_line),
    .arr_wr_en    (arr_wr_en),
    .arr_wr_index (arr_wr_index),
    .arr_wr_tag   (arr_wr_tag),
    .arr_wr_line  (arr_wr_line),
    .arr_wr_dirty (arr_wr_dirty),
    .wren         (wren),
    .rden         (rden),
    .line_addr    (line_addr),
    .wr_line      (wr_line),
    .rd_line      (rd_line),
    .mem_ready    (mem_ready)
  );

  cache_arrays arrays_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_en    (arr_rd_en),
    .rd_index (arr_rd_index),
    .tag      (arr_tag),
    .valid    (arr_valid),
    .dirty    (arr_dirty),
    .line     (arr_line),
    .wr_en    (arr_wr_en),
    .wr_index (arr_wr_index),
    .wr_tag   (arr_wr_tag),
    .wr_line  (arr_wr_line),
    .wr_dirty (arr_wr_dirty)
  );

  dram dram_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wren      (wren),
    .rden      (rden),
    .addr      (line_addr),
    .data_in   (wr_line),
    .data_out  (rd_line),
    .mem_ready (mem_ready)
  );

endmodule

`default_nettype wire

//--- tb/cache_tb_model.svh
// dram byte image and the cache contents as the testbench expects them.
logic [7:0]       mem_image    [cache_pkg::dram_bytes];
cache_pkg::line_t shadow_line  [cache_pkg::cache_sets];
cache_pkg::tag_t  shadow_tag   [cache_pkg::cache_sets];
logic             shadow_valid [cache_pkg::cache_sets];
logic             shadow_dirty [cache_pkg::cache_sets];

function automatic void forget_cache();
  for (int s = 0; s < cache_pkg::cache_sets; s++) begin
    shadow_valid[s] = 1'b0;
    shadow_dirty[s] = 1'b0;
  end
endfunction

function automatic void preset_image();
  for (int i = 0; i < cache_pkg::dram_bytes; i++) begin
    mem_image[i] = 8'(i);                   // low byte of the byte address.
  end
  forget_cache();
endfunction

function automatic cache_pkg::line_t read_image_line(input cache_pkg::line_addr_t la);
  cache_pkg::line_t l;
  for (int b = 0; b < cache_pkg::line_bytes; b++) begin
    l[8*b +: 8] = mem_image[int'(la) * cache_pkg::line_bytes + b];
  end
  return l;
endfunction

function automatic void write_image_line(input cache_pkg::line_addr_t la,
                                         input cache_pkg::line_t l);
  for (int b = 0; b < cache_pkg::line_bytes; b++) begin
    mem_image[int'(la) * cache_pkg::line_bytes + b] = l[8*b +: 8];
  end
endfunction

// expected response of one access, then the state after it.
function automatic void predict_access(input logic store, input cache_pkg::byte_addr_t a,
                                       input cache_pkg::word_t d,
                                       output cache_pkg::word_t rd, output logic h,
                                       output int unsigned lat);
  cache_pkg::tag_t      t;
  cache_pkg::index_t    idx;
  cache_pkg::word_sel_t w;
  t   = a[13:8];
  idx = a[7:4];
  w   = a[3:2];
  h   = shadow_valid[idx] && (shadow_tag[idx] == t);
  if (h) begin
    lat = 2;
  end else if (shadow_valid[idx] && shadow_dirty[idx]) begin
    lat = 13;
    write_image_line({shadow_tag[idx], idx}, shadow_line[idx]);
  end else begin
    lat = 8;
  end
  if (!h) begin
    shadow_line[idx]  = read_image_line({t, idx});
    shadow_tag[idx]   = t;
    shadow_valid[idx] = 1'b1;
    shadow_dirty[idx] = 1'b0;
  end
  rd = shadow_line[idx][cache_pkg::word_bits*w +: cache_pkg::word_bits];
  if (store) begin
    shadow_line[idx][cache_pkg::word_bits*w +: cache_pkg::word_bits] = d;
    shadow_dirty[idx] = 1'b1;
  end
endfunction

//--- tb/cache_tb.sv
`default_nettype none

module cache_tb;

  localparam int drive_delay    = 10;
  localparam int random_count   = 400;
  localparam int directed_count = 23;
  localparam int cycle_limit    = (random_count + directed_count) * 13 + 200;
  localparam cache_pkg::byte_addr_t poke_addr = 14'h1e38;

  logic                  clk;
  logic                  rst_n;
  logic                  req;
  logic                  we;
  cache_pkg::byte_addr_t addr;
  cache_pkg::word_t      wdata;
  cache_pkg::word_t      rdata;
  logic                  busy;
  logic                  done;
  logic                  hit;

  int unsigned           cycle = 0;
  int unsigned           issued_count = 0;
  int unsigned           done_count = 0;
  int unsigned           req_cycle = 0;
  logic                  exp_we;
  logic                  exp_hit;
  int unsigned           exp_lat;
  cache_pkg::byte_addr_t exp_addr;
  cache_pkg::word_t      exp_rdata;
  logic [31:0]           lcg_state;

  `include "cache_tb_model.svh"

  cache_top cache_top_i (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .we    (we),
    .addr  (addr),
    .wdata (wdata),
    .rdata (rdata),
    .busy  (busy),
    .done  (done),
    .hit   (hit)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("tests failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle > cycle_limit) begin
      fail_run($sformatf("timeout after %0d cycles, an access never finished", cycle));
    end
  end

  // outputs are sampled mid-cycle, away from the drive edge.
  always @(negedge clk) begin
    if (rst_n && (issued_count != done_count) && (cycle > req_cycle)) begin
      assert (busy) else fail_run($sformatf("MISMATCH at %0t: busy low during access", $time));
    end
    if (done) begin
      assert (issued_count != done_count)
        else fail_run($sformatf("MISMATCH at %0t: done pulsed with no access in flight",
                                $time));
      assert (cycle - req_cycle == exp_lat)
        else fail_run($sformatf("MISMATCH at %0t: addr 0x%h done after %0d cycles, expected %0d",
                                $time, exp_addr, cycle - req_cycle, exp_lat));
      assert (hit === exp_hit)
        else fail_run($sformatf("MISMATCH at %0t: addr 0x%h hit %b, expected %b",
                                $time, exp_addr, hit, exp_hit));
      if (!exp_we) begin
        assert (rdata === exp_rdata)
          else fail_run($sformatf("MISMATCH at %0t: load 0x%h gave %h, expected %h",
                                  $time, exp_addr, rdata, exp_rdata));
      end
      done_count = done_count + 1;
    end
  end

  // starts just after a rising edge and returns on the edge after done.
  task automatic issue_access(input logic store, input cache_pkg::byte_addr_t a,
                              input cache_pkg::word_t d, input logic poke);
    cache_pkg::word_t rd;
    logic             h;
    int unsigned      lat;
    #drive_delay;
    predict_access(store, a, d, rd, h, lat);
    exp_we    = store;
    exp_addr  = a;
    exp_rdata = rd;
    exp_hit   = h;
    exp_lat   = lat;
    req_cycle = cycle;
    req       = 1'b1;
    we        = store;
    addr      = a;
    wdata     = d;
    issued_count++;
    @(posedge clk);
    #drive_delay;
    req = 1'b0;
    we  = 1'b0;
    if (poke) begin
      assert (busy)
        else fail_run($sformatf("MISMATCH at %0t: busy low right after an accepted request",
                                $time));
      req   = 1'b1;                           // must be dropped by the cache.
      we    = 1'b1;
      addr  = poke_addr;
      wdata = 32'hdead_beef;
      @(posedge clk);
      #drive_delay;
      req = 1'b0;
      we  = 1'b0;
    end
    while (done_count != issued_count) begin
      @(posedge clk);
    end
  endtask

  task automatic apply_reset();
    #drive_delay;
    rst_n = 1'b0;
    req   = 1'b0;
    repeat (5) @(posedge clk);
    #drive_delay;
    rst_n = 1'b1;
    forget_cache();
    assert (!busy && !done && !hit)
      else fail_run($sformatf("MISMATCH at %0t: busy, done or hit high after reset", $time));
    @(posedge clk);
  endtask

  initial begin
    logic [31:0]           r;
    cache_pkg::byte_addr_t a;
    rst_n     = 1'b0;
    req       = 1'b0;
    we        = 1'b0;
    addr      = '0;
    wdata     = '0;
    lcg_state = 32'd16082;
    preset_image();
    @(posedge clk);
    apply_reset();

    // cold loads see the preset pattern.
    issue_access(1'b0, 14'h0000, '0, 1'b0);
    issue_access(1'b0, 14'h0124, '0, 1'b0);
    issue_access(1'b0, 14'h3ff8, '0, 1'b0);
    issue_access(1'b0, 14'h2a0c, '0, 1'b0);

    // store then load in one line.
    issue_access(1'b1, 14'h0124, 32'h1234_5678, 1'b0);
    issue_access(1'b0, 14'h0124, '0, 1'b0);
    issue_access(1'b0, 14'h0120, '0, 1'b0);
    issue_access(1'b0, 14'h0128, '0, 1'b0);
    issue_access(1'b0, 14'h012c, '0, 1'b0);

    // dirty eviction and reload.
    issue_access(1'b1, 14'h0350, 32'hcafe_f00d, 1'b0);
    issue_access(1'b0, 14'h0750, '0, 1'b0);
    issue_access(1'b0, 14'h0350, '0, 1'b0);

    // requests while busy are ignored.
    issue_access(1'b0, 14'h0124, '0, 1'b1);
    issue_access(1'b1, 14'h0b64, 32'h0bad_0001, 1'b1);
    issue_access(1'b0, 14'h0f64, '0, 1'b1);
    issue_access(1'b0, poke_addr, '0, 1'b0);

    for (int n = 0; n < random_count; n++) begin
      r = lcg_next();
      a = {3'b000, r[26:18], 2'b00};          // 2 KiB window.
      if (r[29]) begin
        a[7:4] = {3'b000, r[30]};             // crowd into sets 0 and 1.
      end
      issue_access(r[31], a, lcg_next(), 1'b0);
    end

    // dram keeps written-back data across a reset.
    issue_access(1'b1, 14'h0484, 32'h600d_0001, 1'b0);
    issue_access(1'b1, 14'h0594, 32'h600d_0002, 1'b0);
    issue_access(1'b0, 14'h0994, '0, 1'b0);
    apply_reset();
    issue_access(1'b0, 14'h0484, '0, 1'b0);
    issue_access(1'b0, 14'h0594, '0, 1'b0);
    issue_access(1'b0, 14'h0994, '0, 1'b0);
    issue_access(1'b0, 14'h0594, '0, 1'b0);

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+tb
hw/cache_pkg.sv
hw/dram.sv
hw/cache_arrays.sv
hw/cache_ctrl.sv
hw/cache_top.sv
tb/cache_tb.sv

//--- Bender.yml
package:
  name: cache

sources:
  - files:
      - hw/cache_pkg.sv
      - hw/dram.sv
      - hw/cache_arrays.sv
      - hw/cache_ctrl.sv
      - hw/cache_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/cache_tb.sv
